// ==== bench/fetchUnitTb.sv ====
module fetchUnitTb;

    localparam int rowCount   = 6;
    localparam int rowMax     = 16;                     // words per table row
    localparam int cycleLimit = 40 * rowCount + 200;

    logic                           clk;
    logic                           rst;
    logic                           loadEn;
    logic [fetchPkg::addrWidth-1:0] loadAddr;
    logic [fetchPkg::wordWidth-1:0] loadData;
    logic                           runStart;
    logic                           instrValid;
    logic [fetchPkg::wordWidth-1:0] instr;
    logic [fetchPkg::addrWidth-1:0] instrPc;
    fetchPkg::instrClassE           instrClass;
    logic                           halted;

    //////////////////////////////////////////////////////////////////////
    // stimulus table and reference model
    //////////////////////////////////////////////////////////////////////
    int                             rowLen    [rowCount];
    logic [fetchPkg::addrWidth-1:0] rowAddr   [rowCount][rowMax];
    logic [fetchPkg::wordWidth-1:0] rowData   [rowCount][rowMax];
    int                             rowStop   [rowCount];  // words to check, 0 = run to halt
    logic                           rowSneak  [rowCount];  // load attempt while running
    logic [fetchPkg::addrWidth-1:0] sneakAddr [rowCount];
    logic [fetchPkg::wordWidth-1:0] sneakData [rowCount];

    logic [fetchPkg::wordWidth-1:0] image [fetchPkg::memDepth];  // expected memory image
    logic [fetchPkg::wordWidth-1:0] expWord  [$];
    logic [fetchPkg::addrWidth-1:0] expPc    [$];
    fetchPkg::instrClassE           expClass [$];

    integer seed;
    int     errors;
    int     checks;
    int     cycles = 0;

    fetchUnit fetchUnit_inst (
        .clk        (clk),
        .rst        (rst),
        .loadEn     (loadEn),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .runStart   (runStart),
        .instrValid (instrValid),
        .instr      (instr),
        .instrPc    (instrPc),
        .instrClass (instrClass),
        .halted     (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // hang guard
    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycleLimit)
        begin
            $display("timeout: run passed %0d cycles without finishing", cycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // word builders and class rule
    //////////////////////////////////////////////////////////////////////
    function automatic logic [fetchPkg::wordWidth-1:0] randomWord(input logic [5:0] op);
        logic [31:0] r;
        r = $random(seed);
        return {op, r[25:0]};  // random fields below the opcode
    endfunction

    function automatic logic [fetchPkg::wordWidth-1:0] jumpWord(input logic [4:0] target);
        logic [31:0] r;
        r = $random(seed);
        return {fetchPkg::jmp, r[25:5], target};
    endfunction

    function automatic fetchPkg::instrClassE expectedClass(input logic [31:0] w);
        logic [5:0] op;
        op = w[31:26];
        if (op == fetchPkg::rType || op == fetchPkg::addi)
            return fetchPkg::classAlu;
        if (op == fetchPkg::lw)
            return fetchPkg::classLoad;
        if (op == fetchPkg::sw)
            return fetchPkg::classStore;
        if (op == fetchPkg::beq)
            return fetchPkg::classBranch;
        if (op == fetchPkg::jmp)
            return fetchPkg::classJump;
        if (op == fetchPkg::haltOp)
            return fetchPkg::classHalt;
        return fetchPkg::classUnknown;
    endfunction

    task automatic addWord(input int r, input logic [4:0] a, input logic [31:0] w);
        rowAddr[r][rowLen[r]] = a;
        rowData[r][rowLen[r]] = w;
        rowLen[r]++;
    endtask

    task automatic buildTable();
        for (int r = 0; r < rowCount; r++)
        begin
            rowLen[r]    = 0;
            rowStop[r]   = 0;
            rowSneak[r]  = 1'b0;
            sneakAddr[r] = '0;
            sneakData[r] = '0;
        end
        rowStop[0] = 40;                               // blank memory, wraps past 31
        addWord(1, 0, randomWord(fetchPkg::rType));    // straight line, mixed classes
        addWord(1, 1, randomWord(fetchPkg::addi));
        addWord(1, 2, randomWord(fetchPkg::lw));
        addWord(1, 3, randomWord(fetchPkg::sw));
        addWord(1, 4, randomWord(fetchPkg::beq));
        addWord(1, 5, randomWord(6'b010101));          // unknown
        addWord(1, 6, randomWord(6'b110000));          // unknown
        addWord(1, 7, randomWord(fetchPkg::rType));
        addWord(1, 8, randomWord(fetchPkg::lw));
        addWord(1, 9, fetchPkg::haltWord);
        addWord(2, 0, randomWord(fetchPkg::addi));     // two forward jumps
        addWord(2, 1, jumpWord(6));
        addWord(2, 2, randomWord(fetchPkg::lw));       // shadow of the first jump
        addWord(2, 6, randomWord(fetchPkg::sw));
        addWord(2, 7, jumpWord(12));
        addWord(2, 12, randomWord(fetchPkg::beq));
        addWord(2, 13, fetchPkg::haltWord);
        addWord(3, 0, randomWord(fetchPkg::lw));
        addWord(3, 1, randomWord(fetchPkg::sw));
        addWord(3, 2, randomWord(fetchPkg::rType));
        addWord(3, 3, randomWord(fetchPkg::addi));
        addWord(3, 4, randomWord(fetchPkg::beq));
        addWord(3, 5, fetchPkg::haltWord);
        rowSneak[3]  = 1'b1;                           // would cut the run short if taken
        sneakAddr[3] = 2;
        sneakData[3] = fetchPkg::haltWord;
        // row 4 loads nothing, plain rerun from halted
        addWord(5, 0, randomWord(fetchPkg::sw));       // new program from halted
        addWord(5, 1, randomWord(fetchPkg::lw));
        addWord(5, 2, jumpWord(20));
        addWord(5, 3, fetchPkg::haltWord);
        addWord(5, 20, randomWord(fetchPkg::addi));
        addWord(5, 21, randomWord(6'b011111));
        addWord(5, 22, fetchPkg::haltWord);
    endtask

    // walk the image from word 0 by the jump and halt rules
    task automatic buildTrace(input int limit);
        logic [fetchPkg::addrWidth-1:0] a;
        logic [fetchPkg::wordWidth-1:0] w;
        expWord.delete();
        expPc.delete();
        expClass.delete();
        a = '0;
        for (int n = 0; n < limit; n++)
        begin
            w = image[a];
            expWord.push_back(w);
            expPc.push_back(a);
            expClass.push_back(expectedClass(w));
            if (w[31:26] == fetchPkg::haltOp)
                break;
            if (w[31:26] == fetchPkg::jmp)
                a = w[fetchPkg::addrWidth-1:0];
            else
                a = (int'(a) + 1) % fetchPkg::memDepth;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // drivers and checks
    //////////////////////////////////////////////////////////////////////
    task automatic checkWord(input int r);
        logic [fetchPkg::wordWidth-1:0] w;
        logic [fetchPkg::addrWidth-1:0] a;
        fetchPkg::instrClassE           c;
        checks++;
        assert (expWord.size() > 0)
        else
        begin
            $display("ERR %0t: row %0d extra word %h at %0d", $time, r, instr, instrPc);
            errors++;
        end
        if (expWord.size() > 0)
        begin
            w = expWord.pop_front();
            a = expPc.pop_front();
            c = expClass.pop_front();
            assert (instr === w && instrPc === a && instrClass === c)
            else
            begin
                $display("ERR %0t: row %0d got %h @%0d %s, expected %h @%0d %s", $time, r,
                         instr, instrPc, instrClass.name(), w, a, c.name());
                errors++;
            end
        end
    endtask

    task automatic resetDut(input int n);
        @(negedge clk);
        rst <= 1'b1;
        repeat (n) @(negedge clk);
        rst <= 1'b0;
        checks++;
        assert (!instrValid && !halted)  // values still from the reset edges
        else
        begin
            $display("ERR %0t: outputs not cleared by reset", $time);
            errors++;
        end
        for (int i = 0; i < fetchPkg::memDepth; i++)
            image[i] = '0;
    endtask

    task automatic runRow(input int r);
        int waitCount;
        for (int i = 0; i < rowLen[r]; i++)
        begin
            @(negedge clk);
            loadEn   <= 1'b1;
            loadAddr <= rowAddr[r][i];
            loadData <= rowData[r][i];
            image[rowAddr[r][i]] = rowData[r][i];
        end
        @(negedge clk);
        loadEn <= 1'b0;
        buildTrace((rowStop[r] > 0) ? rowStop[r] : 64);
        @(negedge clk);
        runStart <= 1'b1;
        @(negedge clk);
        runStart <= 1'b0;
        waitCount = 0;
        // until every expected word is seen and, for halting rows, halted is up
        while ((expWord.size() > 0 || (rowStop[r] == 0 && !halted)) && waitCount < 80)
        begin
            @(negedge clk);
            waitCount++;
            if (rowSneak[r] && waitCount == 2)
            begin
                loadEn   <= 1'b1;  // must be dropped, core is running
                loadAddr <= sneakAddr[r];
                loadData <= sneakData[r];
            end
            if (waitCount == 3)
                loadEn <= 1'b0;
            if (expWord.size() > 0)
            begin
                checks++;
                assert (!halted)
                else
                begin
                    $display("ERR %0t: row %0d halted before the halt word", $time, r);
                    errors++;
                end
            end
            if (instrValid)
                checkWord(r);
        end
        loadEn <= 1'b0;
        assert (expWord.size() == 0)
        else
        begin
            $display("row %0d: %0d expected words never appeared", r, expWord.size());
            errors++;
        end
        if (rowStop[r] == 0)
        begin
            repeat (4)
            begin
                @(negedge clk);
                checks++;
                assert (halted && !instrValid)
                else
                begin
                    $display("ERR %0t: row %0d after halt, halted %b valid %b", $time, r,
                             halted, instrValid);
                    errors++;
                end
            end
        end
        else
        begin
            resetDut(3);  // free-running row, only a reset stops it
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        seed     = 63019;
        errors   = 0;
        checks   = 0;
        rst      = 1'b1;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        runStart = 1'b0;
        for (int i = 0; i < fetchPkg::memDepth; i++)
            image[i] = '0;
        buildTable();
        repeat (8) @(negedge clk);
        rst <= 1'b0;
        for (int r = 0; r < rowCount; r++)
            runRow(r);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== design/decodeIf.sv ====
// decoded flags from the decode stage
// flags qualify the word currently held in the decode register
interface decodeIf;

    logic                           isJump;     // jmp opcode
    logic                           isHalt;     // halt opcode
    logic [fetchPkg::addrWidth-1:0] jumpTarget; // low bits of the word
    logic                           decValid;   // word is live, not squashed

    modport decoder (
        output isJump,
        output isHalt,
        output jumpTarget,
        output decValid
    );

    // fsm only needs the redirect and stop flags
    modport control (
        input isJump,
        input isHalt,
        input decValid
    );

    modport pcSide (
        input isJump,
        input jumpTarget,
        input decValid
    );

endinterface

// ==== design/fetchControl.sv ====
module fetchControl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           loadEn,    // debug write request
    input  logic [fetchPkg::addrWidth-1:0] loadAddr,
    input  logic [fetchPkg::wordWidth-1:0] loadData,
    input  logic                           runStart,  // pulse, run from word 0
    input  logic [fetchPkg::addrWidth-1:0] pc,
    decodeIf.control                       dec,
    memPortIf.master                       mem,
    output logic                           clear,
    output logic                           advance,
    output logic                           issue,
    output logic                           halted
);

    fetchPkg::fetchStateE state;
    fetchPkg::fetchStateE nextState;

    logic                           stopped;    // idle or halted, debug owns memory
    logic                           startReq;   // accepted start
    logic                           haltSeen;   // live halt in decode
    logic                           jumpSeen;   // live jump in decode
    logic                           ldWr;       // registered load strobe
    logic [fetchPkg::addrWidth-1:0] ldAddr;
    logic [fetchPkg::wordWidth-1:0] ldData;

    assign stopped  = (state != fetchPkg::stRun);
    assign startReq = stopped && runStart;
    assign haltSeen = dec.decValid && dec.isHalt;
    assign jumpSeen = dec.decValid && dec.isJump;

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        nextState = state;
        case (state)
            fetchPkg::stIdle,
            fetchPkg::stHalted:
                if (runStart)
                    nextState = fetchPkg::stRun;
            fetchPkg::stRun:
                if (haltSeen)
                    nextState = fetchPkg::stHalted;  // halt word already reported
            default:
                nextState = fetchPkg::stIdle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= fetchPkg::stIdle;
        else
            state <= nextState;
    end

    //////////////////////////////////////////////////////////////////////
    // debug load path
    //////////////////////////////////////////////////////////////////////
    // sampled on the rising edge, memory writes on the falling edge after
    // a load that arrives with a start is dropped, the run owns the port
    always_ff @(posedge clk)
    begin
        if (rst)
            ldWr <= 1'b0;
        else
            ldWr <= loadEn && stopped && !runStart;
    end

    always_ff @(posedge clk)
    begin
        ldAddr <= loadAddr;
        ldData <= loadData;
    end

    // memory port steering
    assign mem.addr   = stopped ? ldAddr : pc;  // pc owns the port while running
    assign mem.wrEn   = ldWr;
    assign mem.wrData = ldData;

    // pc and decode controls
    assign clear   = startReq;
    assign advance = !stopped;
    assign issue   = !stopped && !(jumpSeen || haltSeen);  // stale word behind redirect
    assign halted  = (state == fetchPkg::stHalted);

    // no debug write may land while the pipeline is fetching
    noWriteInRun: assert property (
        @(negedge clk) disable iff (rst)
        (state == fetchPkg::stRun) |-> !mem.wrEn
    )
    else
        $error("fetchControl: memory write during run");

endmodule

// ==== design/fetchPkg.sv ====
package fetchPkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////
    localparam int wordWidth   = 32;                // instruction word
    localparam int memDepth    = 32;                // words in the instruction memory
    localparam int addrWidth   = $clog2(memDepth);  // word address, 5 bits
    localparam int opcodeWidth = 6;                 // major opcode field, word[31:26]

    //////////////////////////////////////////////////////////////////////
    // opcodes and classes
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [opcodeWidth-1:0] {
        rType  = 6'b000000,  // funct field selects the alu op
        addi   = 6'b001000,
        lw     = 6'b100011,
        sw     = 6'b101011,
        beq    = 6'b000100,  // classified only, never taken here
        jmp    = 6'b000010,  // target in the low bits
        haltOp = 6'b111111
    } opcodeE;

    typedef enum logic [2:0] {
        classAlu,
        classLoad,
        classStore,
        classBranch,
        classJump,
        classHalt,
        classUnknown
    } instrClassE;

    typedef enum logic [1:0] {
        stIdle,    // debug loading allowed
        stRun,     // fetching
        stHalted   // stopped on a halt word, loading allowed again
    } fetchStateE;

    // halt opcode, all other fields zero
    localparam logic [wordWidth-1:0] haltWord = {haltOp, {(wordWidth-opcodeWidth){1'b0}}};

    // opcode class of a fetched word
    function automatic instrClassE classOf(input logic [wordWidth-1:0] word);
        opcodeE op;
        op = opcodeE'(word[wordWidth-1 -: opcodeWidth]);
        case (op)
            rType, addi: classOf = classAlu;
            lw:          classOf = classLoad;
            sw:          classOf = classStore;
            beq:         classOf = classBranch;
            jmp:         classOf = classJump;
            haltOp:      classOf = classHalt;
            default:     classOf = classUnknown;  // anything not listed above
        endcase
    endfunction

endpackage

// ==== design/fetchUnit.sv ====
module fetchUnit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           loadEn,
    input  logic [fetchPkg::addrWidth-1:0] loadAddr,
    input  logic [fetchPkg::wordWidth-1:0] loadData,
    input  logic                           runStart,
    output logic                           instrValid,
    output logic [fetchPkg::wordWidth-1:0] instr,
    output logic [fetchPkg::addrWidth-1:0] instrPc,
    output fetchPkg::instrClassE           instrClass,
    output logic                           halted
);

    logic                           clear;    // pc to 0
    logic                           advance;  // pc step
    logic                           issue;    // tag of the word being read
    logic [fetchPkg::addrWidth-1:0] pc;

    //////////////////////////////////////////////////////////////////////
    // internal bundles
    //////////////////////////////////////////////////////////////////////
    memPortIf memPort ();
    decodeIf  decBus ();

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////
    fetchControl fetchControl_inst (
        .clk      (clk),
        .rst      (rst),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .runStart (runStart),
        .pc       (pc),
        .dec      (decBus.control),
        .mem      (memPort.master),
        .clear    (clear),
        .advance  (advance),
        .issue    (issue),
        .halted   (halted)
    );

    instructionMemory instructionMemory_inst (
        .clk (clk),
        .rst (rst),
        .mem (memPort.memory)
    );

    programCounter programCounter_inst (
        .clk     (clk),
        .rst     (rst),
        .clear   (clear),
        .advance (advance),
        .dec     (decBus.pcSide),
        .pc      (pc)
    );

    // read word and the pc it came from enter decode together
    instructionDecode instructionDecode_inst (
        .clk        (clk),
        .rst        (rst),
        .word       (memPort.rdData),
        .fetchPc    (pc),
        .issue      (issue),
        .dec        (decBus.decoder),
        .instr      (instr),
        .instrPc    (instrPc),
        .instrClass (instrClass)
    );

    assign instrValid = decBus.decValid;  // squashed words stay invisible

endmodule

// ==== design/instructionDecode.sv ====
module instructionDecode (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [fetchPkg::wordWidth-1:0] word,     // read data from memory
    input  logic [fetchPkg::addrWidth-1:0] fetchPc,  // address that word came from
    input  logic                           issue,    // low squashes the word
    decodeIf.decoder                       dec,
    output logic [fetchPkg::wordWidth-1:0] instr,
    output logic [fetchPkg::addrWidth-1:0] instrPc,
    output fetchPkg::instrClassE           instrClass
);

    logic [fetchPkg::opcodeWidth-1:0] opcode;  // major opcode of the incoming word

    assign opcode = word[fetchPkg::wordWidth-1 -: fetchPkg::opcodeWidth];

    //////////////////////////////////////////////////////////////////////
    // control flags
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            dec.decValid <= 1'b0;
            dec.isJump   <= 1'b0;
            dec.isHalt   <= 1'b0;
        end
        else
        begin
            dec.decValid <= issue;                     // squashed words keep 0
            dec.isJump   <= (opcode == fetchPkg::jmp);
            dec.isHalt   <= (opcode == fetchPkg::haltOp);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // payload
    //////////////////////////////////////////////////////////////////////
    // word, address and class move together every cycle
    always_ff @(posedge clk)
    begin
        instr      <= word;
        instrPc    <= fetchPc;  // pc one stage late to line up with word
        instrClass <= fetchPkg::classOf(word);
    end

    // jump target is the low address bits of the word
    assign dec.jumpTarget = instr[fetchPkg::addrWidth-1:0];

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    flagsExclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(dec.isJump && dec.isHalt)
    )
    else
        $error("instructionDecode: jump and halt flagged together");

endmodule

// ==== design/instructionMemory.sv ====
module instructionMemory (
    input logic      clk,
    input logic      rst,
    memPortIf.memory mem
);

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////
    logic [fetchPkg::wordWidth-1:0] storage [fetchPkg::memDepth];

    // everything happens on the falling edge
    // so the pc set up at the rising edge is stable by then
    always_ff @(negedge clk)
    begin
        if (rst)
        begin
            // debug unit expects a blank image after reset
            for (int i = 0; i < fetchPkg::memDepth; i++)
            begin
                storage[i] <= '0;
            end
            mem.rdData <= '0;
        end
        else if (mem.wrEn)
        begin
            storage[mem.addr] <= mem.wrData;  // debug write, read word held
        end
        else
        begin
            mem.rdData <= storage[mem.addr];  // fetch read
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // address from either the pc or the load port must hit a real word
    addrInRange: assert property (
        @(negedge clk) disable iff (rst)
        !$isunknown(mem.addr) && (int'(mem.addr) < fetchPkg::memDepth)
    )
    else
        $error("instructionMemory: address %0d out of range", mem.addr);

    // a write strobe never carries unknown data into the image
    wrDataKnown: assert property (
        @(negedge clk) disable iff (rst)
        mem.wrEn |-> !$isunknown(mem.wrData)
    )
    else
        $error("instructionMemory: write of unknown data at %0d", mem.addr);

endmodule

// ==== design/memPortIf.sv ====
// single port into the instruction memory
// write and read share addr, a write leaves rdData untouched
interface memPortIf;

    logic [fetchPkg::addrWidth-1:0] addr;   // word address
    logic                           wrEn;   // write instead of read at the falling edge
    logic [fetchPkg::wordWidth-1:0] wrData; // word to store
    logic [fetchPkg::wordWidth-1:0] rdData; // registered read word

    // fetch controller side
    modport master (
        output addr,
        output wrEn,
        output wrData,
        input  rdData
    );

    // memory side
    modport memory (
        input  addr,
        input  wrEn,
        input  wrData,
        output rdData
    );

endinterface

// ==== design/programCounter.sv ====
module programCounter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           clear,    // start of a run
    input  logic                           advance,  // step to the next word
    decodeIf.pcSide                        dec,
    output logic [fetchPkg::addrWidth-1:0] pc
);

    logic jumpTaken;  // live jump word in decode
    logic atLast;     // pc on the top word

    assign jumpTaken = dec.decValid && dec.isJump;
    assign atLast    = (int'(pc) == fetchPkg::memDepth - 1);

    //////////////////////////////////////////////////////////////////////
    // fetch address
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= '0;
        end
        else if (clear)
        begin
            pc <= '0;  // every run starts at word 0
        end
        else if (jumpTaken)
        begin
            // redirect lands on the same edge the
            // word behind the jump is squashed
            pc <= dec.jumpTarget;
        end
        else if (advance)
        begin
            if (atLast)
            begin
                pc <= '0;  // wrap past the top of memory
            end
            else
            begin
                pc <= pc + 1'b1;
            end
        end
        // otherwise hold
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // start squashes decode, so a jump can never race the clear
    noClearOnJump: assert property (
        @(posedge clk) disable iff (rst)
        !(clear && jumpTaken)
    )
    else
        $error("programCounter: clear and jump in the same cycle");

endmodule

// ==== filelist.f ====
design/fetchPkg.sv
design/memPortIf.sv
design/decodeIf.sv
design/instructionMemory.sv
design/programCounter.sv
design/instructionDecode.sv
design/fetchControl.sv
design/fetchUnit.sv
bench/fetchUnitTb.sv
